// ==== hdl/arcade_pkg.sv ====
/*
 * Shared types for the arcade board wrapper.
 * Holds the raw keyboard word, the decoded key levels, the joystick byte,
 * the active-low player word and the two colour formats.
 * Modules use these by scoped name in their ports and import the package
 * in the body where they need the types internally.
 */
package arcade_pkg;

	// Raw keyboard event word from the menu link
	typedef struct packed {
		logic       toggle;   // Flips on every new event
		logic       pressed;  // 1 = make, 0 = break
		logic       extended; // E0 prefix seen
		logic [7:0] code;     // Scan code
	} ps2_key_t;

	// Held level of each mapped key
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic fire3;
	} key_state_t;

	// One joystick, bit 0 is right
	typedef struct packed {
		logic [1:0] spare;
		logic       bomb;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Player input word as the game reads it, all active low
	typedef struct packed {
		logic start;
		logic fire;
		logic bomb;
		logic left;
		logic right;
		logic up;
		logic down;
	} player_in_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb4_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb6_t;

endpackage

// ==== hdl/clock_enables.sv ====
/*
 * Clock enables for the game core, all derived from clk_sys.
 * ce_12 comes every second cycle, ce_6p and ce_6n every fourth cycle on
 * opposite phases, and ce_cpu once every CPU_DIV+1 cycles.
 * All enables are single-cycle pulses and low while reset is held.
 */
`timescale 1ns/1ps

module clock_enables #(
	parameter int CPU_DIV = 13
) (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_12,
	output logic ce_6p,
	output logic ce_6n,
	output logic ce_cpu
);

	localparam int CNT_W = (CPU_DIV < 1) ? 1 : $clog2(CPU_DIV + 1);

	logic [1:0]       phase;
	logic [CNT_W-1:0] cpu_cnt;

	// ==========================================================================
	// Pixel-rate enables
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			phase <= 2'd0;
			ce_12 <= 1'b0;
			ce_6p <= 1'b0;
			ce_6n <= 1'b0;
		end else begin
			phase <= phase + 2'd1;
			ce_12 <= phase[0];
			ce_6p <= phase[0] & ~phase[1]; // Phase 1
			ce_6n <= phase[0] & phase[1];  // Phase 3, two cycles later
		end
	end

	// ==========================================================================
	// CPU-rate enable
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cpu_cnt <= CNT_W'(CPU_DIV);
			ce_cpu  <= 1'b0;
		end else if (cpu_cnt == '0) begin
			cpu_cnt <= CNT_W'(CPU_DIV); // Reload
			ce_cpu  <= 1'b1;
		end else begin
			cpu_cnt <= cpu_cnt - 1'b1;
			ce_cpu  <= 1'b0;
		end
	end

	// Half-pixel enables alternate and never overlap
	a_ce6_phase: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_6p |-> !ce_6n ##2 (ce_6n && !ce_6p));

endmodule

// ==== hdl/key_decoder.sv ====
/*
 * Keyboard event decoder.
 * A new event is seen when the toggle bit of the keyboard word differs
 * from its value on the previous clock. The pressed bit of that event is
 * then stored as the held level of the key its scan code selects.
 * Codes outside the mapped set are dropped.
 */
`timescale 1ns/1ps

module key_decoder (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::ps2_key_t  key_word,
	output arcade_pkg::key_state_t keys
);

	logic toggle_q;  // Toggle seen on the previous clock
	logic new_event;

	assign new_event = key_word.toggle != toggle_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q <= key_word.toggle; // Track input so release fires nothing
			keys     <= '0;
		end else begin
			toggle_q <= key_word.toggle;
			if (new_event) begin
				case (key_word.code)
					8'h75:   keys.up     <= key_word.pressed; // Arrow up
					8'h72:   keys.down   <= key_word.pressed; // Arrow down
					8'h6B:   keys.left   <= key_word.pressed; // Arrow left
					8'h74:   keys.right  <= key_word.pressed; // Arrow right
					8'h76:   keys.coin   <= key_word.pressed; // Esc
					8'h05:   keys.start1 <= key_word.pressed; // F1
					8'h06:   keys.start2 <= key_word.pressed; // F2
					8'h29:   keys.fire1  <= key_word.pressed; // Space
					8'h11:   keys.fire2  <= key_word.pressed; // Alt
					8'h14:   keys.fire3  <= key_word.pressed; // Ctrl
					default: ;
				endcase
			end
		end
	end

	// Held keys only move on the clock after a toggle flip
	a_keys_on_event: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$stable(keys) |-> $past(new_event));

endmodule

// ==== hdl/control_mapper.sv ====
/*
 * Player control merge.
 * Keys and both joysticks are ORed per control. With rotate low the
 * directions are turned a quarter for a rotated screen. Both player words
 * carry the same controls and differ only in their start button.
 * Purely combinational, outputs are active low as the game expects.
 */
`timescale 1ns/1ps

module control_mapper (
	input  arcade_pkg::key_state_t keys,
	input  arcade_pkg::joy_t       joy0,
	input  arcade_pkg::joy_t       joy1,
	input  logic                   rotate,
	output arcade_pkg::player_in_t p1_in,
	output arcade_pkg::player_in_t p2_in,
	output logic                   coin_n
);

	logic up, down, left, right; // Merged, before rotation
	logic m_up, m_down, m_left, m_right;
	logic fire, bomb;
	logic [5:0] ctrl;

	assign up    = keys.up    | joy0.up    | joy1.up;
	assign down  = keys.down  | joy0.down  | joy1.down;
	assign left  = keys.left  | joy0.left  | joy1.left;
	assign right = keys.right | joy0.right | joy1.right;

	// Quarter turn when rotate is low
	assign m_up    = rotate ? up    : left;
	assign m_down  = rotate ? down  : right;
	assign m_left  = rotate ? left  : down;
	assign m_right = rotate ? right : up;

	assign fire = keys.fire1 | joy0.fire | joy1.fire;
	assign bomb = keys.fire2 | joy0.bomb | joy1.bomb;

	assign ctrl = {fire, bomb, m_left, m_right, m_up, m_down};

	assign p1_in  = ~{keys.start1, ctrl};
	assign p2_in  = ~{keys.start2, ctrl};
	assign coin_n = ~keys.coin;

endmodule

// ==== hdl/video_blanker.sv ====
/*
 * Video output stage.
 * Forces colour to black during horizontal or vertical blanking and widens
 * each 4-bit channel to 6 bits by repeating its top two bits.
 * Colour and both syncs are registered together so they stay aligned.
 */
`timescale 1ns/1ps

module video_blanker (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  arcade_pkg::rgb4_t rgb_in,
	input  logic              hblank,
	input  logic              vblank,
	input  logic              hsync,
	input  logic              vsync,
	output arcade_pkg::rgb6_t rgb_out,
	output logic              hsync_o,
	output logic              vsync_o
);

	import arcade_pkg::*;

	logic  blank;
	rgb6_t rgb_next;

	function automatic logic [5:0] widen(input logic [3:0] c);
		widen = {c, c[3:2]}; // Full scale maps to full scale
	endfunction

	assign blank = hblank | vblank;

	always_comb begin
		rgb_next.r = blank ? 6'd0 : widen(rgb_in.r);
		rgb_next.g = blank ? 6'd0 : widen(rgb_in.g);
		rgb_next.b = blank ? 6'd0 : widen(rgb_in.b);
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rgb_out <= '0;
			hsync_o <= 1'b0;
			vsync_o <= 1'b0;
		end else begin
			rgb_out <= rgb_next;
			hsync_o <= hsync;
			vsync_o <= vsync;
		end
	end

endmodule

// ==== hdl/audio_dac.sv ====
/*
 * First-order sigma-delta audio DAC.
 * The sample is added into an accumulator every clock. The carry out of
 * the sample width becomes the one-bit output, so its density of ones
 * follows the sample value. Feed the pin through an RC low-pass.
 */
`timescale 1ns/1ps

module audio_dac #(
	parameter int DAC_BITS = 10
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [DAC_BITS-1:0] sample,
	output logic                audio_o
);

	logic [DAC_BITS:0] acc; // Top bit is the carry of the last add

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			// Drop the old carry and add
			acc <= {1'b0, acc[DAC_BITS-1:0]} + {1'b0, sample};
		end
	end

	assign audio_o = acc[DAC_BITS];

endmodule

// ==== hdl/arcade_io_top.sv ====
/*
 * Board-side I/O wrapper for the arcade game core.
 * Generates the core's clock enables, turns keyboard events and joysticks
 * into player inputs, conditions the game's video and drives the audio pin.
 * The game core, PLL and menu link connect through the plain ports here.
 */
`timescale 1ns/1ps

module arcade_io_top #(
	parameter int CPU_DIV  = 13,
	parameter int DAC_BITS = 10
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  logic                   rotate,
	input  arcade_pkg::ps2_key_t   key_word,
	input  arcade_pkg::joy_t       joy0,
	input  arcade_pkg::joy_t       joy1,
	input  arcade_pkg::rgb4_t      game_rgb,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   hsync,
	input  logic                   vsync,
	input  logic [DAC_BITS-1:0]    game_audio,
	output logic                   ce_12,
	output logic                   ce_6p,
	output logic                   ce_6n,
	output logic                   ce_cpu,
	output arcade_pkg::player_in_t p1_in,
	output arcade_pkg::player_in_t p2_in,
	output logic                   coin_n,
	output arcade_pkg::rgb6_t      vga_rgb,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   audio_l
);

	import arcade_pkg::*;

	key_state_t keys;

	// ==========================================================================
	// Timing and controls
	// ==========================================================================
	clock_enables #(.CPU_DIV(CPU_DIV)) u_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_12   (ce_12),
		.ce_6p   (ce_6p),
		.ce_6n   (ce_6n),
		.ce_cpu  (ce_cpu)
	);

	key_decoder u_key_decoder (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.key_word (key_word),
		.keys     (keys)
	);

	control_mapper u_control_mapper (
		.keys   (keys),
		.joy0   (joy0),
		.joy1   (joy1),
		.rotate (rotate),
		.p1_in  (p1_in),
		.p2_in  (p2_in),
		.coin_n (coin_n)
	);

	// ==========================================================================
	// Video and audio out
	// ==========================================================================
	video_blanker u_video_blanker (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rgb_in  (game_rgb),
		.hblank  (hblank),
		.vblank  (vblank),
		.hsync   (hsync),
		.vsync   (vsync),
		.rgb_out (vga_rgb),
		.hsync_o (vga_hs),
		.vsync_o (vga_vs)
	);

	audio_dac #(.DAC_BITS(DAC_BITS)) u_audio_dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (game_audio),
		.audio_o (audio_l)  // Left channel only
	);

endmodule

// ==== bench/clock_gen.sv ====
/*
 * Testbench clock and power-on reset.
 * Runs clk_sys with a 40 ns period and holds por_n low for the first
 * eight rising edges, then releases it on a falling edge.
 */
`timescale 1ns/1ps

module clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic por_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	initial begin
		por_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		por_n = 1'b1; // Away from the sampling edge
	end

endmodule

// ==== bench/tb_arcade_io.sv ====
/*
 * Testbench for the arcade I/O wrapper.
 * Drives keyboard events, joysticks, video and audio samples on the falling
 * edge, keeps small reference models of the expected outputs, and checks
 * the DUT with concurrent assertions. The first failing check ends the run.
 */
`timescale 1ns/1ps

module tb_arcade_io;

	import arcade_pkg::*;

	localparam int CPU_DIV    = 13;
	localparam int DAC_BITS   = 10;
	localparam int DAC_WIN    = 1 << DAC_BITS;
	localparam int MAX_CYCLES = 12000; // Tests take about 5700 cycles
	localparam logic [7:0] KEY_CODES [10] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h76,
		8'h05, 8'h06, 8'h29, 8'h11, 8'h14};

	logic                clk_sys, por_n, tb_rst_n, rst_n;
	logic                rotate;
	ps2_key_t            key_word;
	joy_t                joy0;
	joy_t                joy1;
	rgb4_t               game_rgb;
	logic                hblank, vblank, hsync, vsync;
	logic [DAC_BITS-1:0] game_audio;
	logic                ce_12, ce_6p, ce_6n, ce_cpu;
	player_in_t          p1_in, p2_in;
	logic                coin_n;
	rgb6_t               vga_rgb;
	logic                vga_hs, vga_vs, audio_l;

	logic        key_event;     // High while a new event is on key_word
	logic [3:0]  ev_slot;
	logic [9:0]  held;          // Same order as KEY_CODES
	logic [14:0] exp_ctrl;      // p1, p2, coin
	logic [19:0] exp_video;     // Colour, hsync, vsync
	logic        exp_cpu;
	int          run_cyc = 0;   // Rising edges since reset release
	int          rst_cyc = 0;
	int          aud_ones = 0;
	int          exp_ones;
	int          cycles = 0;
	logic [31:0] lcg_state;
	string       test_name;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [3:0] key_slot(input logic [7:0] code);
		for (int i = 0; i < 10; i++) begin
			if (KEY_CODES[i] == code)
				return 4'(i);
		end
		return 4'hF; // Not a mapped key
	endfunction

	// Active-low word: start fire bomb left right up down
	function automatic logic [6:0] expect_player(input logic [9:0] k, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot, input logic start);
		logic [7:0] j;
		logic       up, dn, lf, rt, f, b;
		j  = j0 | j1;
		up = k[0] | j[3];
		dn = k[1] | j[2];
		lf = k[2] | j[1];
		rt = k[3] | j[0];
		f  = k[7] | j[4];
		b  = k[8] | j[5];
		if (!rot)
			return ~{start, f, b, dn, up, lf, rt}; // Quarter turn
		return ~{start, f, b, lf, rt, up, dn};
	endfunction

	function automatic logic [17:0] expand_colour(input logic [11:0] c, input logic blank);
		if (blank)
			return 18'd0;
		return {c[11:8], c[11:10], c[7:4], c[7:6], c[3:0], c[3:2]};
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error in test %s, %s: expected %0h, actual %0h", test_name, what,
			expected, actual);
		$display("Errors found");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic report_failure(input string msg);
		$display("Check failed in test %s: %s", test_name, msg);
		$display("Errors found");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed, input logic flip);
		@(negedge clk_sys);
		key_word.toggle   = key_word.toggle ^ flip;
		key_word.pressed  = pressed;
		key_word.extended = 1'b0;
		key_word.code     = code;
		key_event         = flip;
		@(negedge clk_sys);
		key_event = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic drive_joysticks();
		@(negedge clk_sys);
		lcg_state = lcg_step(lcg_state);
		joy0      = lcg_state[31:24];
		joy1      = lcg_state[23:16];
	endtask

	task automatic drive_video();
		@(negedge clk_sys);
		lcg_state = lcg_step(lcg_state);
		game_rgb  = lcg_state[31:20];
		hblank    = lcg_state[19:18] == 2'b00; // Blank about a quarter of the time
		vblank    = lcg_state[17:15] == 3'b000;
		hsync     = lcg_state[14];
		vsync     = lcg_state[13];
	endtask

	// Reset, hold the sample, and let the count run over one full window
	task automatic run_dac(input logic [DAC_BITS-1:0] s);
		@(negedge clk_sys);
		tb_rst_n   = 1'b0;
		game_audio = s;
		exp_ones   = int'(s);
		repeat (3) @(negedge clk_sys);
		tb_rst_n = 1'b1;
		repeat (DAC_WIN + 4) @(negedge clk_sys);
	endtask

	clock_gen u_clock_gen (
		.clk_sys (clk_sys),
		.por_n   (por_n)
	);

	arcade_io_top #(.CPU_DIV(CPU_DIV), .DAC_BITS(DAC_BITS)) dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.rotate     (rotate),
		.key_word   (key_word),
		.joy0       (joy0),
		.joy1       (joy1),
		.game_rgb   (game_rgb),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync      (hsync),
		.vsync      (vsync),
		.game_audio (game_audio),
		.ce_12      (ce_12),
		.ce_6p      (ce_6p),
		.ce_6n      (ce_6n),
		.ce_cpu     (ce_cpu),
		.p1_in      (p1_in),
		.p2_in      (p2_in),
		.coin_n     (coin_n),
		.vga_rgb    (vga_rgb),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.audio_l    (audio_l)
	);

	assign rst_n    = por_n & tb_rst_n;
	assign ev_slot  = key_slot(key_word.code);
	assign exp_ctrl = {expect_player(held, joy0, joy1, rotate, held[5]),
		expect_player(held, joy0, joy1, rotate, held[6]), ~held[4]};
	assign exp_cpu  = run_cyc != 0 && run_cyc % (CPU_DIV + 1) == 0;

	// =========================================================================
	// Reference models and counters
	// =========================================================================
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			held      <= '0;
			exp_video <= '0;
			run_cyc   <= 0;
			aud_ones  <= 0;
			rst_cyc   <= rst_cyc + 1;
		end else begin
			if (key_event && ev_slot != 4'hF) begin
				held[ev_slot] <= key_word.pressed;
			end
			exp_video <= {expand_colour(game_rgb, hblank | vblank), hsync, vsync};
			run_cyc   <= run_cyc + 1;
			rst_cyc   <= 0;
			if (run_cyc >= 1 && run_cyc <= DAC_WIN) begin
				aud_ones <= aud_ones + int'(audio_l); // Ones of the first window
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors found");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	// =========================================================================
	// Checks
	// =========================================================================
	quiet_in_reset: assert property (@(posedge clk_sys) (rst_cyc >= 1 && !rst_n) |->
		({ce_12, ce_6p, ce_6n, ce_cpu, audio_l, vga_hs, vga_vs, vga_rgb} == '0))
		else report_mismatch("outputs in reset", 32'd0,
			32'($sampled({ce_12, ce_6p, ce_6n, ce_cpu, audio_l, vga_hs, vga_vs, vga_rgb})));

	ce12_alternates: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(run_cyc >= 2) |-> (ce_12 != $past(ce_12)))
		else report_failure("ce_12 did not alternate");

	ce6p_every_4: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(run_cyc >= 5) |-> $onehot({ce_6p, $past(ce_6p), $past(ce_6p, 2), $past(ce_6p, 3)}))
		else report_failure("ce_6p was not high exactly once in 4 cycles");

	ce6n_after_ce6p: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(run_cyc >= 3) |-> (ce_6n == $past(ce_6p, 2)))
		else report_failure("ce_6n did not follow ce_6p by 2 cycles");

	cecpu_rate: assert property (@(posedge clk_sys) disable iff (!rst_n) ce_cpu == exp_cpu)
		else report_mismatch("ce_cpu", 32'($sampled(exp_cpu)), 32'($sampled(ce_cpu)));

	controls_match: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{p1_in, p2_in, coin_n} == exp_ctrl)
		else report_mismatch("p1_in p2_in coin_n", 32'($sampled(exp_ctrl)),
			32'($sampled({p1_in, p2_in, coin_n})));

	video_match: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{vga_rgb, vga_hs, vga_vs} == exp_video)
		else report_mismatch("vga rgb hs vs", 32'($sampled(exp_video)),
			32'($sampled({vga_rgb, vga_hs, vga_vs})));

	audio_density: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(run_cyc == DAC_WIN + 1) |-> (aud_ones == exp_ones))
		else report_mismatch("audio_l ones", 32'($sampled(exp_ones)), 32'($sampled(aud_ones)));

	// =========================================================================
	// Stimulus
	// =========================================================================
	initial begin
		rotate     = 1'b1;
		key_word   = '0;
		joy0       = '0;
		joy1       = '0;
		game_rgb   = '0;
		hblank     = 1'b0;
		vblank     = 1'b0;
		hsync      = 1'b0;
		vsync      = 1'b0;
		game_audio = '0;
		tb_rst_n   = 1'b1;
		key_event  = 1'b0;
		exp_ones   = 0;
		lcg_state  = 32'h969d3c1d;
		test_name  = "reset";
		wait (por_n === 1'b1);

		test_name = "clock_enables";
		repeat (40) @(negedge clk_sys);

		test_name = "keyboard";
		for (int i = 0; i < 10; i++) begin
			send_key(KEY_CODES[i], 1'b1, 1'b1);
			send_key(KEY_CODES[i], 1'b0, 1'b1);
		end
		send_key(8'h1C, 1'b1, 1'b1); // Unmapped code
		send_key(8'h76, 1'b1, 1'b0); // Coin with toggle unchanged
		send_key(8'h29, 1'b1, 1'b1);
		send_key(8'h29, 1'b0, 1'b0); // Fire stays held
		send_key(8'h29, 1'b0, 1'b1);

		test_name = "joysticks";
		for (int r = 0; r < 2; r++) begin
			@(negedge clk_sys);
			rotate = r[0];
			repeat (30) drive_joysticks();
		end
		@(negedge clk_sys);
		joy0 = '0;
		joy1 = '0;

		test_name = "rotation";
		for (int r = 0; r < 2; r++) begin
			@(negedge clk_sys);
			rotate = r[0];
			for (int i = 0; i < 4; i++) begin
				send_key(KEY_CODES[i], 1'b1, 1'b1);
				send_key(KEY_CODES[i], 1'b0, 1'b1);
			end
		end

		test_name = "video";
		repeat (200) drive_video();
		@(negedge clk_sys);
		hblank = 1'b0;
		vblank = 1'b0;

		test_name = "audio";
		repeat (5) begin
			lcg_state = lcg_step(lcg_state);
			run_dac(lcg_state[31 -: DAC_BITS]);
		end

		$display("No errors");
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/arcade_pkg.sv
hdl/clock_enables.sv
hdl/key_decoder.sv
hdl/control_mapper.sv
hdl/video_blanker.sv
hdl/audio_dac.sv
hdl/arcade_io_top.sv
bench/clock_gen.sv
bench/tb_arcade_io.sv

// ==== Makefile ====
# Verilator simulation of the arcade I/O wrapper

VERILATOR ?= verilator
TOP       ?= tb_arcade_io
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

.PHONY: sim clean

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
